/* Makefile */
# Verilator build and run of the TX datapath testbench

VERILATOR ?= verilator
TOP       ?= tb_aib_adapttxdp
FILELIST  ?= aib_adapttxdp_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_STR  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* aib_adapttxdp_async_fifo.sv */
// 16-entry dual-clock FIFO with Gray-coded pointers. Reads advance on every
// rd_en without an empty check, since the phase-comp scheme keeps both
// sides rate matched. Writes are dropped once 16 entries are held.
// Flags use programmable thresholds and reflect each side's own view, so
// they lag the opposite side by the two-stage pointer sync.
`timescale 1ns/1ps

module aib_adapttxdp_async_fifo (
  input  logic                     wr_clk,
  input  logic                     wr_rst_n,
  input  logic                     wr_en,
  input  aib_txdp_pkg::txdp_word_t wr_data,
  input  logic                     rd_clk,
  input  logic                     rd_rst_n,
  input  logic                     rd_en,
  output aib_txdp_pkg::txdp_word_t rd_data,
  input  aib_txdp_pkg::txdp_cfg_t  cfg,
  output aib_txdp_pkg::txdp_flags_t flags
);

  import aib_txdp_pkg::*;

  txdp_word_t mem [FIFO_DEPTH];                     // Storage, no reset

  fifo_ptr_t wr_bin_q, wr_gray_q, wr_bin_nxt;       // Write domain pointer
  fifo_ptr_t rd_gray_s1_q, rd_gray_s2_q;            // Read ptr into wr domain
  fifo_ptr_t rd_bin_q, rd_gray_q, rd_bin_nxt;       // Read domain pointer
  fifo_ptr_t wr_gray_s1_q, wr_gray_s2_q;            // Write ptr into rd domain
  fifo_ptr_t wr_occ, rd_occ;                        // Per-domain occupancy
  logic      wr_push;

  function automatic fifo_ptr_t gray2bin(input fifo_ptr_t g);
    fifo_ptr_t b;
    b[FIFO_AW] = g[FIFO_AW];
    for (int i = FIFO_AW - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // ************************************************************************
  // Write domain
  // ************************************************************************
  assign wr_occ     = wr_bin_q - gray2bin(rd_gray_s2_q);
  assign wr_push    = wr_en & ~wr_occ[FIFO_AW];     // Drop when 16 held
  assign wr_bin_nxt = wr_bin_q + 1'b1;

  always_ff @(posedge wr_clk) begin
    if (wr_push) begin
      mem[wr_bin_q[FIFO_AW-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      wr_bin_q     <= '0;
      wr_gray_q    <= '0;
      rd_gray_s1_q <= '0;
      rd_gray_s2_q <= '0;
    end else begin
      rd_gray_s1_q <= rd_gray_q;                    // Two-stage pointer sync
      rd_gray_s2_q <= rd_gray_s1_q;
      if (wr_push) begin
        wr_bin_q  <= wr_bin_nxt;
        wr_gray_q <= wr_bin_nxt ^ (wr_bin_nxt >> 1);  // Bin to Gray
      end
    end
  end

  // ************************************************************************
  // Read domain
  // ************************************************************************
  assign rd_occ     = gray2bin(wr_gray_s2_q) - rd_bin_q;
  assign rd_bin_nxt = rd_bin_q + 1'b1;
  assign rd_data    = mem[rd_bin_q[FIFO_AW-1:0]];  // Async read, registered outside

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      rd_bin_q     <= '0;
      rd_gray_q    <= '0;
      wr_gray_s1_q <= '0;
      wr_gray_s2_q <= '0;
    end else begin
      wr_gray_s1_q <= wr_gray_q;
      wr_gray_s2_q <= wr_gray_s1_q;
      if (rd_en) begin
        rd_bin_q  <= rd_bin_nxt;
        rd_gray_q <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
      end
    end
  end

  // Threshold flags, full side counts down from depth
  assign flags.full   = wr_occ >= (fifo_ptr_t'(FIFO_DEPTH) - {1'b0, cfg.thr_full});
  assign flags.pfull  = wr_occ >= (fifo_ptr_t'(FIFO_DEPTH) - {1'b0, cfg.thr_pfull});
  assign flags.empty  = rd_occ <= {1'b0, cfg.thr_empty};
  assign flags.pempty = rd_occ <= {1'b0, cfg.thr_pempty};

endmodule

/* aib_adapttxdp_cfg.sv */
// Zero-wait-state APB slave with the CTRL and THR registers, clocked by
// rd_clk. No pready. Unmapped addresses return zero with pslverr high in
// the access phase, and writes to them are ignored. Register outputs feed
// both clock domains directly, so change them only while the datapath is
// held in reset or idle.
`timescale 1ns/1ps

module aib_adapttxdp_cfg (
  input  logic                    clk,              // rd_clk
  input  logic                    rd_rst_n,
  input  aib_txdp_pkg::apb_addr_t paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  aib_txdp_pkg::apb_data_t pwdata,
  output aib_txdp_pkg::apb_data_t prdata,
  output logic                    pslverr,
  output aib_txdp_pkg::txdp_cfg_t cfg_o
);

  import aib_txdp_pkg::*;

  txdp_cfg_t cfg_q;
  logic      access;                                // APB access phase
  logic      hit_ctrl, hit_thr;

  assign access   = psel & penable;
  assign hit_ctrl = (paddr == ADDR_CTRL);
  assign hit_thr  = (paddr == ADDR_THR);

  always_ff @(posedge clk) begin
    if (!rd_rst_n) begin
      cfg_q <= '0;                                  // FIFO_1X, markers off
    end else if (access && pwrite) begin
      if (hit_ctrl) begin
        cfg_q.fifo_mode <= fifo_mode_e'(pwdata[1:0]);
        cfg_q.wm_en     <= pwdata[2];
        cfg_q.gen2_mode <= pwdata[3];
        cfg_q.mkbit     <= pwdata[8:4];
        cfg_q.rd_delay  <= pwdata[15:12];
      end
      if (hit_thr) begin
        cfg_q.thr_empty  <= pwdata[3:0];
        cfg_q.thr_pempty <= pwdata[7:4];
        cfg_q.thr_pfull  <= pwdata[11:8];
        cfg_q.thr_full   <= pwdata[15:12];
      end
    end
  end

  // Read mux, reserved bits read zero
  always_comb begin
    prdata = '0;
    if (hit_ctrl) begin
      prdata = {16'h0, cfg_q.rd_delay, 3'b000, cfg_q.mkbit,
                cfg_q.gen2_mode, cfg_q.wm_en, cfg_q.fifo_mode};
    end else if (hit_thr) begin
      prdata = {16'h0, cfg_q.thr_full, cfg_q.thr_pfull,
                cfg_q.thr_pempty, cfg_q.thr_empty};
    end
  end

  assign pslverr = access & ~(hit_ctrl | hit_thr);  // Unmapped address
  assign cfg_o   = cfg_q;

endmodule

/* aib_adapttxdp_fifo.sv */
// Marker insertion, phase-comp enable generation and output register around
// the dual-clock FIFO. Writing starts a fixed three wr_clk stages after
// wr_rst_n releases; reading follows the synced write start plus 2..6
// rd_clk stages. There is no back-pressure: upstream must supply a word on
// every cycle with wr_ready high. REG_MOD blocks both sides and holds dout
// at zero; no bypass path exists.
`timescale 1ns/1ps

module aib_adapttxdp_fifo (
  input  logic                      wr_clk,
  input  logic                      wr_rst_n,
  input  logic                      rd_clk,
  input  logic                      rd_rst_n,
  input  aib_txdp_pkg::txdp_cfg_t   cfg,
  input  aib_txdp_pkg::txdp_word_t  data_in,
  output logic                      wr_ready,
  output aib_txdp_pkg::txdp_word_t  dout,
  output logic                      dout_valid,
  output aib_txdp_pkg::txdp_flags_t flags
);

  import aib_txdp_pkg::*;

  txdp_word_t        wr_data;                       // Marker-processed word
  txdp_word_t        fifo_out;
  logic [LANE_W-1:0] mk_pos;                        // One-hot marker bit in a slice
  logic              mk_hit;
  logic [1:0]        top_slice;                     // Slice that carries the 1
  logic              mark_en;
  logic              gen1_mark;                     // 2X bit-0 marker case
  logic              reg_mode;
  logic              wr_en, rd_en;
  logic [2:0]        wr_start_q;                    // Write start shift
  logic              wren_sync2;
  logic [6:3]        wren_dly_q;                    // Extra read delay stages
  logic              rden_sel;

  assign reg_mode = (cfg.fifo_mode == REG_MOD);

  // ************************************************************************
  // Marker insertion
  // ************************************************************************
  always_comb begin
    mk_pos = '0;
    mk_hit = 1'b1;
    if (cfg.mkbit[1]) begin                         // Lowest set bit wins
      mk_pos[LANE_W-4] = 1'b1;
    end else if (cfg.mkbit[2]) begin
      mk_pos[LANE_W-3] = 1'b1;
    end else if (cfg.mkbit[3]) begin
      mk_pos[LANE_W-2] = 1'b1;
    end else if (cfg.mkbit[4]) begin
      mk_pos[LANE_W-1] = 1'b1;
    end else begin
      mk_hit = 1'b0;                                // Only bit 0 or none
    end
  end

  assign top_slice = (cfg.fifo_mode == FIFO_4X) ? 2'd3 : 2'd1;
  assign mark_en   = cfg.wm_en & mk_hit &
                     ((cfg.fifo_mode == FIFO_4X) | (cfg.fifo_mode == FIFO_2X));
  assign gen1_mark = cfg.wm_en & ~mk_hit & cfg.mkbit[0] & ~cfg.gen2_mode &
                     (cfg.fifo_mode == FIFO_2X);

  always_comb begin
    wr_data = data_in;                              // Default pass through
    if (mark_en) begin
      for (int s = 0; s < NUM_LANES; s++) begin
        wr_data[s*LANE_W +: LANE_W] = (data_in[s*LANE_W +: LANE_W] & ~mk_pos) |
                                      ((s == int'(top_slice)) ? mk_pos : '0);
      end
      if (cfg.fifo_mode == FIFO_2X) begin
        wr_data[WORD_W-1:2*LANE_W] = '0;            // Upper half unused at 2:1
      end
    end else if (gen1_mark) begin
      wr_data                          = '0;        // Slice 0 only
      wr_data[LANE_W-1]                = 1'b1;
      wr_data[LANE_W-2:LANE_W/2]       = data_in[LANE_W-2:LANE_W/2];
      wr_data[LANE_W/2-2:0]            = data_in[LANE_W/2-2:0];
    end
  end

  // ************************************************************************
  // Phase-comp write and read enables
  // ************************************************************************
  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      wr_start_q <= '0;
    end else begin
      wr_start_q <= {wr_start_q[1:0], 1'b1};        // Fills with ones, then stays
    end
  end

  assign wr_ready = wr_start_q[2];
  assign wr_en    = wr_ready & ~reg_mode;

  aib_bitsync wren_sync_i (
    .clk      (rd_clk),
    .rd_rst_n (rd_rst_n),
    .data_in  (wr_ready),
    .data_out (wren_sync2)
  );

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      wren_dly_q <= '0;
    end else begin
      wren_dly_q <= {wren_dly_q[5:3], wren_sync2};  // Stages 3..6
    end
  end

  always_comb begin
    case (cfg.rd_delay)
      4'd3:    rden_sel = wren_dly_q[3];
      4'd4:    rden_sel = wren_dly_q[4];
      4'd5:    rden_sel = wren_dly_q[5];
      4'd6:    rden_sel = wren_dly_q[6];
      default: rden_sel = wren_sync2;               // Minimum two stages
    endcase
  end

  assign rd_en = rden_sel & ~reg_mode;

  aib_adapttxdp_async_fifo async_fifo_i (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (fifo_out),
    .cfg      (cfg),
    .flags    (flags)
  );

  // Output register, zero when not reading
  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      dout       <= '0;
      dout_valid <= 1'b0;
    end else begin
      dout       <= rd_en ? fifo_out : '0;
      dout_valid <= rd_en;
    end
  end

endmodule

/* aib_adapttxdp_top.f */
aib_txdp_pkg.sv
aib_bitsync.sv
aib_adapttxdp_async_fifo.sv
aib_adapttxdp_fifo.sv
aib_adapttxdp_cfg.sv
aib_adapttxdp_top.sv
tb_clkgen.sv
tb_aib_adapttxdp.sv

/* aib_adapttxdp_top.sv */
// TX phase-compensation datapath top: APB config block plus the FIFO
// datapath. APB runs on rd_clk. Data streams one word per wr_clk with
// no handshake; dout_valid marks each output word. No lane bonding.
`timescale 1ns/1ps

module aib_adapttxdp_top (
  input  logic                      wr_clk,
  input  logic                      wr_rst_n,
  input  logic                      rd_clk,
  input  logic                      rd_rst_n,
  input  aib_txdp_pkg::apb_addr_t   paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  aib_txdp_pkg::apb_data_t   pwdata,
  output aib_txdp_pkg::apb_data_t   prdata,
  output logic                      pslverr,
  input  aib_txdp_pkg::txdp_word_t  data_in,
  output logic                      wr_ready,
  output aib_txdp_pkg::txdp_word_t  dout,
  output logic                      dout_valid,
  output aib_txdp_pkg::txdp_flags_t flags
);

  import aib_txdp_pkg::*;

  txdp_cfg_t cfg_w;                                 // Quasi-static config

  aib_adapttxdp_cfg cfg_i (
    .clk      (rd_clk),
    .rd_rst_n (rd_rst_n),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pslverr  (pslverr),
    .cfg_o    (cfg_w)
  );

  aib_adapttxdp_fifo fifo_i (
    .wr_clk     (wr_clk),
    .wr_rst_n   (wr_rst_n),
    .rd_clk     (rd_clk),
    .rd_rst_n   (rd_rst_n),
    .cfg        (cfg_w),
    .data_in    (data_in),
    .wr_ready   (wr_ready),
    .dout       (dout),
    .dout_valid (dout_valid),
    .flags      (flags)
  );

endmodule

/* aib_bitsync.sv */
// Two-flop synchronizer for one level signal. Reset is synchronous to the
// destination clock; all users sit in the read domain. Pulses shorter than
// two destination cycles can be lost.
`timescale 1ns/1ps

module aib_bitsync (
  input  logic clk,                                 // Destination clock
  input  logic rd_rst_n,                            // Sync reset, active low
  input  logic data_in,                             // Async level in
  output logic data_out                             // Synced level
);

  logic meta_q;                                     // First stage, may go metastable
  logic sync_q;

  always_ff @(posedge clk) begin
    if (!rd_rst_n) begin
      meta_q <= 1'b0;
      sync_q <= 1'b0;
    end else begin
      meta_q <= data_in;
      sync_q <= meta_q;
    end
  end

  assign data_out = sync_q;

endmodule

/* aib_txdp_pkg.sv */
// Shared widths, mode encodings, APB map and config/status structs for the
// TX phase-compensation datapath. Configuration is quasi-static and is
// sampled by both clock domains without synchronizers.
// Thresholds are FIFO_AW bits wide, so a full-count threshold of 16 is
// not representable.
package aib_txdp_pkg;

  // ************************************************************************
  // Widths
  // ************************************************************************
  localparam int LANE_W     = 80;                   // One lane slice
  localparam int NUM_LANES  = 4;                    // Slices per word
  localparam int WORD_W     = NUM_LANES * LANE_W;   // 320-bit FIFO word
  localparam int FIFO_AW    = 4;                    // 16 entries
  localparam int FIFO_DEPTH = 1 << FIFO_AW;

  typedef logic [WORD_W-1:0]  txdp_word_t;          // Data word
  typedef logic [FIFO_AW-1:0] fifo_thr_t;           // Flag threshold
  typedef logic [FIFO_AW:0]   fifo_ptr_t;           // Pointer with wrap bit
  typedef logic [3:0]         rd_delay_t;           // Read delay select
  typedef logic [4:0]         mkbit_t;              // Marker position one-hot

  // FIFO mode, matches CTRL[1:0]
  typedef enum logic [1:0] {
    FIFO_1X = 2'b00,                                // Full rate
    FIFO_2X = 2'b01,                                // Half rate
    FIFO_4X = 2'b10,                                // Quarter rate
    REG_MOD = 2'b11                                 // FIFO disabled
  } fifo_mode_e;

  typedef struct packed {
    fifo_mode_e fifo_mode;
    logic       wm_en;                              // Marker insert enable
    logic       gen2_mode;
    mkbit_t     mkbit;
    rd_delay_t  rd_delay;
    fifo_thr_t  thr_empty;
    fifo_thr_t  thr_pempty;
    fifo_thr_t  thr_pfull;
    fifo_thr_t  thr_full;
  } txdp_cfg_t;

  // full/pfull from write side, empty/pempty from read side
  typedef struct packed {
    logic full;
    logic pfull;
    logic empty;
    logic pempty;
  } txdp_flags_t;

  // ************************************************************************
  // APB register map
  // ************************************************************************
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  localparam apb_addr_t ADDR_CTRL = 8'h00;          // Mode, markers, rd delay
  localparam apb_addr_t ADDR_THR  = 8'h04;          // Flag thresholds

endpackage

/* tb_aib_adapttxdp.sv */
// Testbench for the TX phase-compensation datapath. Both clocks run at 4 ns
// and rd_clk lags by 1.3 ns, so the read side drains exactly the words written.
// A test stops traffic by pulling wr_rst_n low. The word on data_in at that
// edge still lands in the FIFO and is expected on dout.
// Outputs are sampled on falling edges. Configuration is written after
// rd_rst_n releases and while wr_rst_n is still held low.
`timescale 1ns/1ps

module tb_aib_adapttxdp;

  import aib_txdp_pkg::*;

  localparam int          WORDS       = 200;        // Words per traffic test
  localparam int          REG_WORDS   = 100;
  localparam int          NUM_TESTS   = 22;
  localparam real         WATCHDOG_NS = real'(NUM_TESTS * (WORDS + 200)) * 4.0;
  localparam int unsigned SEED        = 32'h2302_1b70;
  localparam apb_data_t   CTRL_MASK   = 32'h0000_F1FF;  // Defined CTRL fields
  localparam apb_data_t   THR_MASK    = 32'h0000_FFFF;
  localparam txdp_flags_t RESET_FLAGS = '{full: 1'b0, pfull: 1'b0, empty: 1'b1, pempty: 1'b1};

  logic        wr_clk, rd_clk, wr_rst_n, rd_rst_n;
  apb_addr_t   paddr;
  logic        psel, penable, pwrite, pslverr;
  apb_data_t   pwdata, prdata;
  txdp_word_t  data_in, dout;
  logic        wr_ready, dout_valid;
  txdp_flags_t flags;

  txdp_cfg_t   cur_cfg;                             // Config used by the reference
  txdp_word_t  exp_q [$];                           // Expected output words
  int          rdy_cycles = 0;                      // Falling edges with wr_ready high
  int          wr_hi_edges = 0;                     // wr_clk edges with wr_rst_n high
  int          ready_rd_edges = 0;                  // rd_clk edges that saw wr_ready high
  logic        check_flags;                         // Flag check each rd cycle
  string       test_name;

  tb_clkgen #(.PERIOD_NS(4.0), .PHASE_NS(0.0)) wr_clk_i (.clk(wr_clk));
  tb_clkgen #(.PERIOD_NS(4.0), .PHASE_NS(1.3)) rd_clk_i (.clk(rd_clk));

  aib_adapttxdp_top dut_i (
    .wr_clk (wr_clk), .wr_rst_n (wr_rst_n), .rd_clk (rd_clk), .rd_rst_n (rd_rst_n),
    .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
    .pwdata (pwdata), .prdata (prdata), .pslverr (pslverr),
    .data_in (data_in), .wr_ready (wr_ready), .dout (dout),
    .dout_valid (dout_valid), .flags (flags)
  );

  // ************************************************************************
  // Reference model and checks
  // ************************************************************************
  function automatic txdp_word_t marker_ref(input txdp_cfg_t c, input txdp_word_t w);
    txdp_word_t r;
    int         pos;
    int         top;
    r   = w;
    pos = -1;
    top = (c.fifo_mode == FIFO_4X) ? 3 : 1;         // Slice that gets the 1
    for (int b = 4; b >= 1; b--) begin
      if (c.mkbit[b]) begin
        pos = LANE_W - 5 + b;                       // Lowest set bit remains
      end
    end
    if (!c.wm_en || !(c.fifo_mode == FIFO_4X || c.fifo_mode == FIFO_2X)) begin
      return w;
    end
    if (pos >= 0) begin
      for (int s = 0; s < NUM_LANES; s++) begin
        r[s*LANE_W + pos] = (s == top);
      end
      if (c.fifo_mode == FIFO_2X) begin
        r[WORD_W-1:2*LANE_W] = '0;
      end
    end else if (c.mkbit[0] && !c.gen2_mode && c.fifo_mode == FIFO_2X) begin
      r                 = '0;                       // Slice 0 only
      r[LANE_W-1:0]     = w[LANE_W-1:0];
      r[LANE_W-1]       = 1'b1;
      r[LANE_W/2-1]     = 1'b0;
    end
    return r;
  endfunction

  // Two sync flops plus 0..4 extra stages, then the output register
  function automatic int read_latency(input rd_delay_t d);
    return ((d >= 4'd3) && (d <= 4'd6)) ? int'(d) + 1 : 3;
  endfunction

  function automatic txdp_word_t rand_word();
    txdp_word_t w;
    for (int i = 0; i < WORD_W / 32; i++) begin
      w[i*32 +: 32] = $urandom;
    end
    return w;
  endfunction

  function automatic txdp_cfg_t make_cfg(input fifo_mode_e mode, input logic wm,
                                         input logic g2, input mkbit_t mk,
                                         input rd_delay_t dly);
    txdp_cfg_t c;
    c           = '0;                               // Thresholds stay zero
    c.fifo_mode = mode;
    c.wm_en     = wm;
    c.gen2_mode = g2;
    c.mkbit     = mk;
    c.rd_delay  = dly;
    return c;
  endfunction

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic compare_word(input string name, input txdp_word_t exp, input txdp_word_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_flags(input string name, input txdp_flags_t exp,
                               input txdp_flags_t act);
    if (act !== exp) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_apb(input string name, input apb_data_t exp, input apb_data_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_strobe(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // ************************************************************************
  // Bus and traffic tasks
  // ************************************************************************
  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic err);
    @(posedge rd_clk);                              // Setup phase
    paddr   <= addr;
    pwrite  <= wr;
    pwdata  <= wdata;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge rd_clk);                              // Access phase
    penable <= 1'b1;
    @(negedge rd_clk);
    rdata = prdata;
    err   = pslverr;
    @(posedge rd_clk);                              // Register updates here
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic run_traffic(input int words);
    int base;
    base = rdy_cycles;
    @(posedge wr_clk);
    wr_rst_n <= 1'b1;
    data_in  <= rand_word();
    while (rdy_cycles - base < words - 1) begin
      @(posedge wr_clk);
      data_in <= rand_word();
    end
    wr_rst_n <= 1'b0;                               // Last word lands on this edge
  endtask

  task automatic drain_output();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 64) begin
      @(posedge rd_clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Test %s left %0d written words that never came out", test_name, exp_q.size());
      abort_run();
    end
    repeat (20) @(posedge rd_clk);                  // Catch late spurious words
  endtask

  task automatic run_test(input string name, input txdp_cfg_t c, input int words,
                          input logic flag_chk);
    apb_data_t rd;
    logic      err;
    test_name = name;
    @(posedge rd_clk);
    rd_rst_n <= 1'b0;                               // wr_rst_n is already low
    repeat (10) @(posedge rd_clk);
    rd_rst_n <= 1'b1;
    cur_cfg = c;
    apb_xfer(1'b1, ADDR_CTRL, {16'h0, c.rd_delay, 3'b000, c.mkbit, c.gen2_mode,
                               c.wm_en, c.fifo_mode}, rd, err);
    apb_xfer(1'b1, ADDR_THR, {16'h0, c.thr_full, c.thr_pfull, c.thr_pempty,
                              c.thr_empty}, rd, err);
    check_flags = flag_chk;
    run_traffic(words);
    drain_output();
    check_flags = 1'b0;
  endtask

  // ************************************************************************
  // Monitors
  // ************************************************************************
  always @(posedge wr_clk) begin
    if (wr_rst_n === 1'b1) begin
      wr_hi_edges <= wr_hi_edges + 1;
    end else begin
      wr_hi_edges <= 0;
    end
  end

  always @(posedge rd_clk) begin
    if (wr_ready === 1'b1) begin
      ready_rd_edges <= ready_rd_edges + 1;
    end else begin
      ready_rd_edges <= 0;
    end
  end

  always @(negedge wr_clk) begin
    compare_strobe({test_name, "_ready"}, wr_hi_edges >= 3, wr_ready);  // Third edge out of reset
    if (wr_ready === 1'b1) begin                    // Word captured on next rise
      rdy_cycles++;
      if (cur_cfg.fifo_mode != REG_MOD) begin
        exp_q.push_back(marker_ref(cur_cfg, data_in));
      end
    end
  end

  always @(negedge rd_clk) begin
    if (rd_rst_n === 1'b1) begin
      if (ready_rd_edges > 0) begin                 // While the write side streams
        compare_strobe({test_name, "_valid"},
                       cur_cfg.fifo_mode != REG_MOD &&
                       ready_rd_edges >= read_latency(cur_cfg.rd_delay),
                       dout_valid);
      end
      if (dout_valid) begin
        if (exp_q.size() == 0) begin
          $display("Test %s produced an output word that was never written", test_name);
          abort_run();
        end else begin
          compare_word(test_name, exp_q.pop_front(), dout);
        end
      end else begin
        compare_word({test_name, "_idle"}, '0, dout);  // Cleared when idle
      end
      if (check_flags) begin
        compare_flags({test_name, "_flags"}, RESET_FLAGS, flags);
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all tests completed");
    $display("CHECKS FAILED");
    $fatal(1, "Timeout");
  end

  // ************************************************************************
  // Test sequence
  // ************************************************************************
  initial begin
    apb_data_t rd;
    logic      err;
    void'($urandom(SEED));
    wr_rst_n    = 1'b0;
    rd_rst_n    = 1'b0;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    data_in     = '0;
    cur_cfg     = '0;
    check_flags = 1'b0;
    test_name   = "reset";
    repeat (10) @(posedge rd_clk);
    rd_rst_n <= 1'b1;
    @(negedge rd_clk);
    compare_flags("reset_flags", RESET_FLAGS, flags);  // Before wr_ready rises

    test_name = "apb_regs";                         // Reserved bits set on purpose
    apb_xfer(1'b1, ADDR_CTRL, 32'hA5A5_7E3D, rd, err);
    apb_xfer(1'b1, ADDR_THR, 32'h5A5A_C3E1, rd, err);
    apb_xfer(1'b0, ADDR_CTRL, '0, rd, err);
    compare_apb("apb_ctrl", 32'hA5A5_7E3D & CTRL_MASK, rd);
    compare_apb("apb_ctrl_err", 32'd0, apb_data_t'(err));
    apb_xfer(1'b0, ADDR_THR, '0, rd, err);
    compare_apb("apb_thr", 32'h5A5A_C3E1 & THR_MASK, rd);
    apb_xfer(1'b1, 8'h08, 32'hFFFF_FFFF, rd, err);
    compare_apb("apb_bad_wr_err", 32'd1, apb_data_t'(err));
    apb_xfer(1'b0, 8'h08, '0, rd, err);
    compare_apb("apb_bad_rd_err", 32'd1, apb_data_t'(err));
    apb_xfer(1'b0, ADDR_CTRL, '0, rd, err);
    compare_apb("apb_ctrl_kept", 32'hA5A5_7E3D & CTRL_MASK, rd);
    apb_xfer(1'b0, ADDR_THR, '0, rd, err);
    compare_apb("apb_thr_kept", 32'h5A5A_C3E1 & THR_MASK, rd);

    for (int d = 2; d <= 6; d++) begin
      run_test($sformatf("fifo1x_dly%0d", d),
               make_cfg(FIFO_1X, 1'b0, 1'b0, '0, rd_delay_t'(d)), WORDS, 1'b0);
    end
    for (int b = 4; b >= 1; b--) begin              // Bits above b set as well
      run_test($sformatf("fifo4x_mk%0d", b),
               make_cfg(FIFO_4X, 1'b1, 1'b0, mkbit_t'(5'b11110 << (b - 1)), 4'd2),
               WORDS, 1'b0);
    end
    for (int g = 0; g <= 1; g++) begin
      for (int b = 4; b >= 0; b--) begin
        run_test($sformatf("fifo2x_g%0d_mk%0d", g, b),
                 make_cfg(FIFO_2X, 1'b1, g[0], mkbit_t'(1 << b), 4'd3), WORDS, 1'b0);
      end
    end
    run_test("reg_mode", make_cfg(REG_MOD, 1'b0, 1'b0, '0, 4'd2), REG_WORDS, 1'b1);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* tb_clkgen.sv */
// Free-running testbench clock. The first rising edge comes at
// PHASE_NS + PERIOD_NS/2. Real-valued delays need a 1ps precision.
`timescale 1ns/1ps

module tb_clkgen #(
  parameter real PERIOD_NS = 4.0,                   // Full period
  parameter real PHASE_NS  = 0.0                    // Start offset
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    #(PHASE_NS);                                    // Hold low for the offset
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule
